/* logic/daq_tx_pkg.sv */
/*
 * Transmit-side shared definitions
 * Widths, channel count, source codes and the beat and config types
 * used throughout the two-channel signal generator
 */

`default_nettype none

package daq_tx_pkg;

  localparam int CHANNELS         = 2;
  localparam int SAMPLE_WIDTH     = 16;
  localparam int PHASE_BITS       = 32;
  localparam int SCALE_WIDTH      = 18;
  localparam int SCALE_INT_BITS   = 2;
  localparam int SCALE_FRAC_BITS  = SCALE_WIDTH - SCALE_INT_BITS;
  localparam int OFFSET_WIDTH     = 14;
  localparam int SOURCE_SEL_WIDTH = 3;
  localparam int CFG_VALUE_WIDTH  = 32;

  // Unity gain in the scale field
  localparam int SCALE_ONE = 1 << SCALE_FRAC_BITS;

  // Source codes, anything at or past 1 + 2*CHANNELS reads as zero
  localparam int SRC_ZERO     = 0;
  localparam int SRC_SAW_BASE = 1;
  localparam int SRC_TRI_BASE = 1 + CHANNELS;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [PHASE_BITS-1:0]          phase_t;

  typedef enum logic [1:0] {
    FIELD_PHASE_INC    = 2'd0,
    FIELD_SOURCE       = 2'd1,
    FIELD_SCALE_OFFSET = 2'd2,
    FIELD_ENABLE       = 2'd3
  } cfg_field_e;

  // Scale/offset value packs scale on top, offset in the low bits
  typedef struct packed {
    logic                       strobe;
    logic                       channel;
    cfg_field_e                 field;
    logic [CFG_VALUE_WIDTH-1:0] value;
  } cfg_write_t;

  typedef struct packed {
    logic                          enable;
    phase_t                        phase_inc;
    logic [SOURCE_SEL_WIDTH-1:0]   source;
    logic signed [SCALE_WIDTH-1:0] scale;
    logic signed [OFFSET_WIDTH-1:0] offset;
  } chan_cfg_t;

  typedef struct packed {
    logic    valid;
    logic    trigger;
    sample_t sample;
  } tx_beat_t;

endpackage

`default_nettype wire

/* logic/tx_config_regs.sv */
/*
 * Transmit configuration registers
 * Holds enable, phase increment, source and scale/offset per channel,
 * updated one field at a time by the configuration write strobe
 */

`timescale 1ns/1ns
`default_nettype none

module tx_config_regs
  import daq_tx_pkg::*;
(
  input  wire logic       dac_clk,
  input  wire logic       rst_n,
  input  wire cfg_write_t cfg,
  output chan_cfg_t       chan_cfg [CHANNELS]
);

  // Split of the scale/offset write word
  logic signed [SCALE_WIDTH-1:0]  wr_scale;
  logic signed [OFFSET_WIDTH-1:0] wr_offset;

  assign wr_scale  = cfg.value[CFG_VALUE_WIDTH-1 -: SCALE_WIDTH];
  assign wr_offset = cfg.value[OFFSET_WIDTH-1:0];

  always_ff @(posedge dac_clk) begin
    if (!rst_n) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        chan_cfg[ch].enable    <= 1'b0;
        chan_cfg[ch].phase_inc <= '0;
        // Each channel starts on its own sawtooth
        chan_cfg[ch].source    <= SOURCE_SEL_WIDTH'(SRC_SAW_BASE + ch);
        chan_cfg[ch].scale     <= SCALE_WIDTH'(SCALE_ONE);
        chan_cfg[ch].offset    <= '0;
      end
    end else if (cfg.strobe) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (cfg.channel == 1'(ch)) begin
          unique case (cfg.field)
            FIELD_PHASE_INC: chan_cfg[ch].phase_inc <= cfg.value[PHASE_BITS-1:0];
            FIELD_SOURCE:    chan_cfg[ch].source    <= cfg.value[SOURCE_SEL_WIDTH-1:0];
            FIELD_SCALE_OFFSET: begin
              chan_cfg[ch].scale  <= wr_scale;
              chan_cfg[ch].offset <= wr_offset;
            end
            FIELD_ENABLE:    chan_cfg[ch].enable    <= cfg.value[0];
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/phase_accumulator.sv */
/*
 * Phase accumulator
 * One phase word per channel, stepped by its increment while enabled,
 * with a trigger on the beat where the phase wraps
 */

`timescale 1ns/1ns
`default_nettype none

module phase_accumulator
  import daq_tx_pkg::*;
(
  input  wire logic      dac_clk,
  input  wire logic      rst_n,
  input  wire chan_cfg_t chan_cfg [CHANNELS],
  output phase_t         phase    [CHANNELS],
  output tx_beat_t       beat     [CHANNELS]
);

  phase_t next_phase [CHANNELS];

  // First enabled beat stays at 0, later beats add the increment
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      next_phase[ch] = phase[ch] + (beat[ch].valid ? chan_cfg[ch].phase_inc : '0);
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      beat[ch].sample <= '0;
      if (!rst_n || !chan_cfg[ch].enable) begin
        phase[ch]        <= '0;
        beat[ch].valid   <= 1'b0;
        beat[ch].trigger <= 1'b0;
      end else begin
        phase[ch]        <= next_phase[ch];
        beat[ch].valid   <= 1'b1;
        // Wrapped if the sum came out below the old phase
        beat[ch].trigger <= (next_phase[ch] < phase[ch]);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/waveform_shaper.sv */
/*
 * Waveform shaper
 * Sawtooth and triangle samples from each channel's phase, one cycle
 */

`timescale 1ns/1ns
`default_nettype none

module waveform_shaper
  import daq_tx_pkg::*;
(
  input  wire logic     dac_clk,
  input  wire logic     rst_n,
  input  wire phase_t   phase    [CHANNELS],
  input  wire tx_beat_t beat_in  [CHANNELS],
  output sample_t       saw      [CHANNELS],
  output sample_t       tri_wave [CHANNELS],
  output tx_beat_t      beat     [CHANNELS]
);

  localparam int TOP = PHASE_BITS - 1;

  sample_t saw_next [CHANNELS];
  logic [SAMPLE_WIDTH-1:0] fold [CHANNELS];

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      saw_next[ch] = phase[ch][TOP -: SAMPLE_WIDTH];
      // Second half of the period runs back down
      fold[ch] = phase[ch][TOP-1 -: SAMPLE_WIDTH];
      if (phase[ch][TOP]) begin
        fold[ch] = ~fold[ch];
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      saw[ch]         <= saw_next[ch];
      tri_wave[ch]    <= {~fold[ch][SAMPLE_WIDTH-1], fold[ch][SAMPLE_WIDTH-2:0]};
      beat[ch].sample <= saw_next[ch];
      if (!rst_n) begin
        beat[ch].valid   <= 1'b0;
        beat[ch].trigger <= 1'b0;
      end else begin
        beat[ch].valid   <= beat_in[ch].valid;
        beat[ch].trigger <= beat_in[ch].trigger;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/source_mux.sv */
/*
 * Transmit source mux
 * Picks zero or any channel's sawtooth or triangle for each output
 * channel, registered together with the channel's own valid and trigger
 */

`timescale 1ns/1ns
`default_nettype none

module source_mux
  import daq_tx_pkg::*;
(
  input  wire logic      dac_clk,
  input  wire logic      rst_n,
  input  wire chan_cfg_t chan_cfg [CHANNELS],
  input  wire sample_t   saw      [CHANNELS],
  input  wire sample_t   tri_wave [CHANNELS],
  input  wire tx_beat_t  beat_in  [CHANNELS],
  output tx_beat_t       beat     [CHANNELS]
);

  sample_t pick [CHANNELS];

  //////////////////////////////////////////////////
  // Source decode
  //////////////////////////////////////////////////
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      // SRC_ZERO and codes past the triangles fall through to zero
      pick[ch] = '0;
      for (int k = 0; k < CHANNELS; k++) begin
        if (chan_cfg[ch].source == SOURCE_SEL_WIDTH'(SRC_SAW_BASE + k)) begin
          pick[ch] = saw[k];
        end
        if (chan_cfg[ch].source == SOURCE_SEL_WIDTH'(SRC_TRI_BASE + k)) begin
          pick[ch] = tri_wave[k];
        end
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      beat[ch].sample <= pick[ch];
      if (!rst_n) begin
        beat[ch].valid   <= 1'b0;
        beat[ch].trigger <= 1'b0;
      end else begin
        beat[ch].valid   <= beat_in[ch].valid;
        beat[ch].trigger <= beat_in[ch].trigger;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/dac_prescaler.sv */
/*
 * DAC prescaler
 * Signed fixed-point scale, then floor shift, offset and saturation,
 * two pipeline stages per channel
 */

`timescale 1ns/1ns
`default_nettype none

module dac_prescaler
  import daq_tx_pkg::*;
(
  input  wire logic      dac_clk,
  input  wire logic      rst_n,
  input  wire chan_cfg_t chan_cfg [CHANNELS],
  input  wire tx_beat_t  beat_in  [CHANNELS],
  output tx_beat_t       beat     [CHANNELS]
);

  localparam int PROD_WIDTH = SAMPLE_WIDTH + SCALE_WIDTH;
  // One spare bit so the offset add cannot overflow
  localparam int SUM_WIDTH  = PROD_WIDTH - SCALE_FRAC_BITS + 1;

  localparam logic signed [SUM_WIDTH-1:0] SAT_MAX =
    SUM_WIDTH'((1 << (SAMPLE_WIDTH - 1)) - 1);
  localparam logic signed [SUM_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

  logic signed [PROD_WIDTH-1:0] product    [CHANNELS];
  logic                         s1_valid   [CHANNELS];
  logic                         s1_trigger [CHANNELS];
  logic signed [SUM_WIDTH-1:0]  shifted    [CHANNELS];
  logic signed [SUM_WIDTH-1:0]  sum        [CHANNELS];
  sample_t                      clipped    [CHANNELS];

  //////////////////////////////////////////////////
  // Stage 1: multiply
  //////////////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      product[ch] <= $signed(beat_in[ch].sample) * chan_cfg[ch].scale;
      if (!rst_n) begin
        s1_valid[ch]   <= 1'b0;
        s1_trigger[ch] <= 1'b0;
      end else begin
        s1_valid[ch]   <= beat_in[ch].valid;
        s1_trigger[ch] <= beat_in[ch].trigger;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage 2: shift, offset, clamp
  //////////////////////////////////////////////////
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      // Arithmetic shift rounds toward minus infinity
      shifted[ch] = SUM_WIDTH'(product[ch] >>> SCALE_FRAC_BITS);
      sum[ch]     = shifted[ch] + SUM_WIDTH'(chan_cfg[ch].offset);
      if (sum[ch] > SAT_MAX) begin
        clipped[ch] = SAMPLE_WIDTH'(SAT_MAX);
      end else if (sum[ch] < SAT_MIN) begin
        clipped[ch] = SAMPLE_WIDTH'(SAT_MIN);
      end else begin
        clipped[ch] = SAMPLE_WIDTH'(sum[ch]);
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      beat[ch].sample <= clipped[ch];
      if (!rst_n) begin
        beat[ch].valid   <= 1'b0;
        beat[ch].trigger <= 1'b0;
      end else begin
        beat[ch].valid   <= s1_valid[ch];
        beat[ch].trigger <= s1_trigger[ch];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/signal_gen_top.sv */
/*
 * Two-channel signal generator top
 * Config registers beside a phase, shape, mux and prescale pipeline,
 * four cycles from phase to DAC output
 */

`timescale 1ns/1ns
`default_nettype none

module signal_gen_top
  import daq_tx_pkg::*;
(
  input  wire logic       dac_clk,
  input  wire logic       rst_n,
  input  wire cfg_write_t cfg,
  output tx_beat_t        dac_out [CHANNELS]
);

  chan_cfg_t chan_cfg   [CHANNELS];
  phase_t    phase      [CHANNELS];
  tx_beat_t  acc_beat   [CHANNELS];
  sample_t   saw        [CHANNELS];
  sample_t   tri_wave   [CHANNELS];
  tx_beat_t  shape_beat [CHANNELS];
  tx_beat_t  mux_beat   [CHANNELS];

  //////////////////////////////////////////////////
  // Settings
  //////////////////////////////////////////////////
  tx_config_regs tx_config_regs_i (
    .dac_clk,
    .rst_n,
    .cfg,
    .chan_cfg
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  phase_accumulator phase_accumulator_i (
    .dac_clk,
    .rst_n,
    .chan_cfg,
    .phase,
    .beat     (acc_beat)
  );

  waveform_shaper waveform_shaper_i (
    .dac_clk,
    .rst_n,
    .phase,
    .beat_in  (acc_beat),
    .saw,
    .tri_wave,
    .beat     (shape_beat)
  );

  // Cross-channel selection happens here
  source_mux source_mux_i (
    .dac_clk,
    .rst_n,
    .chan_cfg,
    .saw,
    .tri_wave,
    .beat_in  (shape_beat),
    .beat     (mux_beat)
  );

  dac_prescaler dac_prescaler_i (
    .dac_clk,
    .rst_n,
    .chan_cfg,
    .beat_in  (mux_beat),
    .beat     (dac_out)
  );

endmodule

`default_nettype wire

/* verif/tb_signal_gen.sv */
/*
 * Signal generator testbench
 * Directed tests of reset, sawtooth, triangle with cross-channel mux,
 * prescale saturation and wrap trigger against a reference model
 */

`timescale 1ns/1ns
`default_nettype none

module tb_signal_gen
  import daq_tx_pkg::*;
;

  localparam int BEATS      = 64;
  localparam int MAX_CYCLES = 3000;

  logic       dac_clk = 1'b0;
  logic       rst_n;
  cfg_write_t cfg;
  tx_beat_t   dac_out [CHANNELS];

  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  int          test_errors;
  int          pass_count = 0;
  int          fail_count = 0;
  string       cur_test;

  sample_t got_sample [CHANNELS][BEATS];
  logic    got_trig   [CHANNELS][BEATS];
  int      got_count  [CHANNELS];

  signal_gen_top uut (
    .dac_clk,
    .rst_n,
    .cfg,
    .dac_out
  );

  always #50 dac_clk = ~dac_clk;

  always @(posedge dac_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Random bits and reference model
  //////////////////////////////////////////////////
  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic sample_t saw_of(input phase_t p);
    return sample_t'(p[31:16]);
  endfunction

  // Fold the lower half-period bits, then recentre as signed
  function automatic sample_t tri_of(input phase_t p);
    logic [15:0] f;
    f = p[30:15];
    if (p[31]) f = ~f;
    return sample_t'({~f[15], f[14:0]});
  endfunction

  function automatic sample_t prescale(input sample_t s, input logic signed [17:0] sc,
                                       input logic signed [13:0] off);
    longint v;
    v = (longint'(s) * longint'(sc)) >>> 16;
    v = v + longint'(off);
    if (v > 32767) v = 32767;
    if (v < -32768) v = -32768;
    return sample_t'(v);
  endfunction

  //////////////////////////////////////////////////
  // Stimulus and checking helpers
  //////////////////////////////////////////////////
  task automatic apply_reset();
    @(posedge dac_clk);
    rst_n <= 1'b0;
    cfg   <= '0;
    repeat (5) @(posedge dac_clk);
    rst_n <= 1'b1;
  endtask

  task automatic write_cfg(input logic ch, input cfg_field_e f, input logic [31:0] v);
    @(posedge dac_clk);
    cfg <= '{strobe: 1'b1, channel: ch, field: f, value: v};
  endtask

  task automatic end_writes();
    @(posedge dac_clk);
    cfg <= '0;
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (exp !== act) begin
      $display("Mismatch %s expected %0d actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch %s expected %b actual %b", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
    apply_reset();
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      pass_count++;
      $display("[ok] %s", cur_test);
    end else begin
      fail_count++;
      $display("[failed] %s with %0d errors", cur_test, test_errors);
    end
  endtask

  // Gathers the first BEATS valid beats of each masked channel
  task automatic collect_beats(input logic [CHANNELS-1:0] mask);
    int  cycles;
    bit  done;
    for (int ch = 0; ch < CHANNELS; ch++) got_count[ch] = 0;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < BEATS + 20) begin
      @(negedge dac_clk);
      cycles++;
      done = 1'b1;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (mask[ch] && dac_out[ch].valid && got_count[ch] < BEATS) begin
          got_sample[ch][got_count[ch]] = dac_out[ch].sample;
          got_trig[ch][got_count[ch]]   = dac_out[ch].trigger;
          got_count[ch]++;
        end
        if (mask[ch] && got_count[ch] < BEATS) done = 1'b0;
      end
    end
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (mask[ch] && got_count[ch] < BEATS) begin
        $display("Error in %s: channel %0d gave only %0d of %0d valid beats in time",
                 cur_test, ch, got_count[ch], BEATS);
        test_errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_reset_state();
    start_test("reset_state");
    repeat (20) begin
      @(negedge dac_clk);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        check_flag("reset_state valid", 1'b0, dac_out[ch].valid);
        check_flag("reset_state trigger", 1'b0, dac_out[ch].trigger);
      end
    end
    finish_test();
  endtask

  task automatic test_sawtooth();
    phase_t inc;
    start_test("sawtooth");
    inc = rand_bits(32);
    write_cfg(1'b0, FIELD_PHASE_INC, inc);
    write_cfg(1'b0, FIELD_ENABLE, 32'd1);
    end_writes();
    collect_beats(2'b01);
    for (int k = 0; k < got_count[0]; k++) begin
      check_sample("sawtooth", saw_of(inc * phase_t'(k)), got_sample[0][k]);
    end
    finish_test();
  endtask

  task automatic test_triangle_mux();
    phase_t                    inc1;
    logic signed [17:0]        scale0;
    logic signed [13:0]        offset1;
    start_test("triangle_mux");
    inc1    = rand_bits(32);
    scale0  = 18'(rand_bits(18));
    offset1 = 14'(rand_bits(14));
    write_cfg(1'b1, FIELD_PHASE_INC, inc1);
    write_cfg(1'b1, FIELD_SOURCE, SRC_ZERO);
    write_cfg(1'b1, FIELD_SCALE_OFFSET, {18'(SCALE_ONE), offset1});
    write_cfg(1'b0, FIELD_SOURCE, SRC_TRI_BASE + 1);
    write_cfg(1'b0, FIELD_SCALE_OFFSET, {scale0, 14'd0});
    // Channel 1 starts one cycle ahead of channel 0
    write_cfg(1'b1, FIELD_ENABLE, 32'd1);
    write_cfg(1'b0, FIELD_ENABLE, 32'd1);
    end_writes();
    collect_beats(2'b11);
    for (int k = 0; k < got_count[0]; k++) begin
      check_sample("triangle_mux ch0",
                   prescale(tri_of(inc1 * phase_t'(k + 1)), scale0, 14'sd0),
                   got_sample[0][k]);
    end
    for (int k = 0; k < got_count[1]; k++) begin
      check_sample("triangle_mux ch1", sample_t'(offset1), got_sample[1][k]);
    end
    finish_test();
  endtask

  task automatic test_scale_saturation();
    phase_t             inc;
    logic signed [17:0] scale;
    logic signed [13:0] offset;
    int                 hi_hits;
    int                 lo_hits;
    start_test("scale_saturation");
    inc     = 32'h0300_0000 + rand_bits(20);
    // Largest positive scale just below 2.0
    scale   = 18'sh1ffff;
    offset  = -14'sd100;
    hi_hits = 0;
    lo_hits = 0;
    write_cfg(1'b0, FIELD_PHASE_INC, inc);
    write_cfg(1'b0, FIELD_SCALE_OFFSET, {scale, offset});
    write_cfg(1'b0, FIELD_ENABLE, 32'd1);
    end_writes();
    collect_beats(2'b01);
    for (int k = 0; k < got_count[0]; k++) begin
      check_sample("scale_saturation",
                   prescale(saw_of(inc * phase_t'(k)), scale, offset), got_sample[0][k]);
      if (got_sample[0][k] == 16'sh7fff) hi_hits++;
      if (got_sample[0][k] == -16'sh8000) lo_hits++;
    end
    if (hi_hits == 0 || lo_hits == 0) begin
      $display("Error in %s: output never pinned at both limits", cur_test);
      test_errors++;
    end
    finish_test();
  endtask

  task automatic test_wrap_trigger();
    phase_t inc;
    phase_t prev;
    phase_t cur;
    start_test("wrap_trigger");
    inc = 32'h9000_0000 | rand_bits(28);
    write_cfg(1'b0, FIELD_PHASE_INC, inc);
    write_cfg(1'b0, FIELD_ENABLE, 32'd1);
    end_writes();
    collect_beats(2'b01);
    prev = '0;
    for (int k = 0; k < got_count[0]; k++) begin
      cur = inc * phase_t'(k);
      check_flag("wrap_trigger", (k > 0) && (cur < prev), got_trig[0][k]);
      prev = cur;
    end
    finish_test();
  endtask

  initial begin
    rst_n      = 1'b0;
    cfg        = '0;
    lfsr_state = 32'hfeab_8cab;
    test_reset_state();
    test_sawtooth();
    test_triangle_mux();
    test_scale_saturation();
    test_wrap_trigger();
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
logic/daq_tx_pkg.sv
logic/tx_config_regs.sv
logic/phase_accumulator.sv
logic/waveform_shaper.sv
logic/source_mux.sv
logic/dac_prescaler.sv
logic/signal_gen_top.sv
verif/tb_signal_gen.sv

/* run_sim.sh */
#!/bin/sh
# Compile the testbench with Verilator, run it, and check the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_signal_gen -f build.f \
  && ./obj_dir/Vtb_signal_gen > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "Simulation finished: PASS" sim.log \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
